// ==== dv/tb_qsgmii_rx.sv ====
/*
 * Random QSGMII receive stream with CFG_COUNT of 8 and a fixed LFSR seed.
 * The lane sequences go out once with plain K28.5 commas and must not align,
 * then again with lane 0 commas sent as K28.1. One lane carries a corrupted
 * cfg2 and a done lane later sees a disparity error.
 */
`timescale 1ns/10ps

module tb_qsgmii_rx
    import tbi_pkg::*, sgmii_pkg::*;
();

    localparam int NUM_LANES = 4;
    localparam int CFG_COUNT = 8;
    localparam int SLOT_BYTES = 8;
    localparam int MAIN_SLOTS = 22;
    localparam int POST_SLOTS = 4;
    localparam int STREAM_CYCLES = (2 * MAIN_SLOTS + POST_SLOTS) * SLOT_BYTES * NUM_LANES;
    localparam int TIMEOUT_CYCLES = 4 * STREAM_CYCLES + 200;
    localparam logic [15:0] SEED = 16'd63117;

    logic tbi_rx_clk;
    logic rst;
    tbi_byte_t rx_byte;
    logic rx_is_k;
    logic rx_disp_err;
    logic lane_aligned;
    logic [NUM_LANES-1:0] an_start;
    logic [NUM_LANES-1:0] an_ack;
    logic [NUM_LANES-1:0] an_idle;
    logic [NUM_LANES-1:0] an_done;
    logic [NUM_LANES-1:0] link_up;
    logic [NUM_LANES-1:0] full_duplex;
    link_speed_t [NUM_LANES-1:0] link_speed;

    // Lane model with one {is_k, byte} entry per byte
    logic [8:0] lane_mem [NUM_LANES][MAIN_SLOTS * SLOT_BYTES];
    sgmii_cfg_t ack_word [NUM_LANES];
    logic [NUM_LANES-1:0] done_seen;
    logic [15:0] lfsr_state;
    int errors;
    int checks;
    int cycle_count;
    int bad_lane;
    int err_lane;

    qsgmii_rx_top #(.NUM_LANES(NUM_LANES), .CFG_COUNT(CFG_COUNT)) u_dut (
        .tbi_rx_clk   (tbi_rx_clk),
        .rst          (rst),
        .rx_byte      (rx_byte),
        .rx_is_k      (rx_is_k),
        .rx_disp_err  (rx_disp_err),
        .lane_aligned (lane_aligned),
        .an_start     (an_start),
        .an_ack       (an_ack),
        .an_idle      (an_idle),
        .an_done      (an_done),
        .link_up      (link_up),
        .full_duplex  (full_duplex),
        .link_speed   (link_speed)
    );

    initial
    begin
        tbi_rx_clk = 1'b0;
        forever #4 tbi_rx_clk = ~tbi_rx_clk;
    end

    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        logic [15:0] next;
        next = state >> 1;
        if (state[0])
            next = next ^ 16'hB400;
        return next;
    endfunction

    task automatic random_bits(input int n, output logic [15:0] value);
        value = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            value = {value[14:0], lfsr_state[0]};
        end
    endtask

    task automatic check_value(input string name, input logic [15:0] expected,
                               input logic [15:0] actual);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("** Error %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // A config pair is K28.5 D21.5 cfg1 cfg1 K28.5 D2.2 cfg2 cfg2 with the low byte first
    function automatic logic [8:0] pair_code(input int b, input sgmii_cfg_t cfg1,
                                             input sgmii_cfg_t cfg2);
        case (b)
        0, 4: return {1'b1, K28_5};
        1: return {1'b0, D21_5};
        2: return {1'b0, cfg1[7:0]};
        3: return {1'b0, cfg1[15:8]};
        5: return {1'b0, D2_2};
        6: return {1'b0, cfg2[7:0]};
        default: return {1'b0, cfg2[15:8]};
        endcase
    endfunction

    function automatic logic [8:0] idle_code(input int b);
        if ((b % 2) == 0)
            return {1'b1, K28_5};
        return {1'b0, ((b % 4) == 1) ? D5_6 : D16_2};
    endfunction

    function automatic logic [8:0] line_code(input int lane, input logic [8:0] code);
        if ((lane == 0) && (code == {1'b1, K28_5}))
            return {1'b1, K28_1};
        return code;
    endfunction

    task automatic build_lane(input int lane, input logic corrupt);
        logic [15:0] word;
        logic [15:0] pick;
        logic [15:0] flip;
        int n_ability;
        int bad_pair;
        int slot;
        random_bits(16, word);
        word[CFG_VALID_BIT] = 1'b1;
        word[CFG_ACK_BIT] = 1'b0;
        random_bits(2, pick);
        n_ability = 2 + int'(pick[1:0]);
        random_bits(2, pick);
        bad_pair = corrupt ? int'(pick[1:0]) : -1;
        random_bits(4, pick);
        flip = 16'd1 << pick[3:0];
        ack_word[lane] = word | (16'd1 << CFG_ACK_BIT);
        slot = 0;
        // The first pair is lost to the restart step and the search
        for (int p = 0; p < CFG_COUNT + 1 + n_ability + 4; p++)
        begin
            for (int b = 0; b < SLOT_BYTES; b++)
            begin
                if (p <= CFG_COUNT)
                    lane_mem[lane][slot * SLOT_BYTES + b] = pair_code(b, '0, '0);
                else if (p <= CFG_COUNT + n_ability)
                    lane_mem[lane][slot * SLOT_BYTES + b] = pair_code(b, word, word);
                else
                    lane_mem[lane][slot * SLOT_BYTES + b] = pair_code(b, ack_word[lane],
                        (p - CFG_COUNT - 1 - n_ability == bad_pair) ?
                        ack_word[lane] ^ flip : ack_word[lane]);
            end
            slot++;
        end
        for (int s = slot; s < MAIN_SLOTS; s++)
            for (int b = 0; b < SLOT_BYTES; b++)
                lane_mem[lane][s * SLOT_BYTES + b] = idle_code(b);
    endtask

    task automatic drive_byte(input logic [8:0] code, input logic err);
        @(posedge tbi_rx_clk);
        rx_is_k <= code[8];
        rx_byte <= code[7:0];
        rx_disp_err <= err;
    endtask

    task automatic check_lane_up(input int lane, input string tag);
        sgmii_cfg_t word;
        word = ack_word[lane];
        check_value($sformatf("%s lane %0d an_start", tag, lane), 16'd1, 16'(an_start[lane]));
        check_value($sformatf("%s lane %0d an_ack", tag, lane), 16'd1, 16'(an_ack[lane]));
        check_value($sformatf("%s lane %0d an_idle", tag, lane), 16'd1, 16'(an_idle[lane]));
        check_value($sformatf("%s lane %0d an_done", tag, lane), 16'd1, 16'(an_done[lane]));
        check_value($sformatf("%s lane %0d link_up", tag, lane),
            16'(word[CFG_LINK_BIT]), 16'(link_up[lane]));
        check_value($sformatf("%s lane %0d full_duplex", tag, lane),
            16'(word[CFG_DUPLEX_BIT]), 16'(full_duplex[lane]));
        check_value($sformatf("%s lane %0d link_speed", tag, lane),
            16'(word[CFG_SPEED_MSB:CFG_SPEED_LSB]), 16'(link_speed[lane]));
    endtask

    always @(negedge tbi_rx_clk)
    begin
        if (rst)
            done_seen <= '0;
        else
            done_seen <= done_seen | an_done;
    end

    initial
    begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES)
        begin
            @(posedge tbi_rx_clk);
            cycle_count++;
        end
        $display("Timeout: the stream did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Finished with errors");
        $finish;
    end

    initial
    begin
        logic [15:0] pick;
        rst = 1'b1;
        rx_byte = '0;
        rx_is_k = 1'b0;
        rx_disp_err = 1'b0;
        errors = 0;
        checks = 0;
        lfsr_state = SEED;
        random_bits(2, pick);
        bad_lane = int'(pick[1:0]);
        random_bits(2, pick);
        err_lane = (bad_lane + 1 + int'(pick[1:0]) % 3) % NUM_LANES;
        for (int i = 0; i < NUM_LANES; i++)
            build_lane(i, i == bad_lane);
        repeat (3) @(posedge tbi_rx_clk);
        rst <= 1'b0;

        // Complete lane sequences without K28.1 must not align or complete anything
        for (int s = 0; s < MAIN_SLOTS; s++)
            for (int b = 0; b < SLOT_BYTES; b++)
                for (int lane = 0; lane < NUM_LANES; lane++)
                begin
                    drive_byte(lane_mem[lane][s * SLOT_BYTES + b], 1'b0);
                    @(negedge tbi_rx_clk);
                    check_value("unaligned lane_aligned", 16'd0, 16'(lane_aligned));
                    check_value("unaligned an_done", 16'd0, 16'(an_done));
                end

        for (int s = 0; s < MAIN_SLOTS; s++)
            for (int b = 0; b < SLOT_BYTES; b++)
                for (int lane = 0; lane < NUM_LANES; lane++)
                    drive_byte(line_code(lane, lane_mem[lane][s * SLOT_BYTES + b]), 1'b0);
        @(negedge tbi_rx_clk);
        check_value("aligned lane_aligned", 16'd1, 16'(lane_aligned));
        for (int i = 0; i < NUM_LANES; i++)
        begin
            if (i == bad_lane)
            begin
                check_value($sformatf("corrupted lane %0d done seen", i), 16'd0,
                    16'(done_seen[i]));
                check_value($sformatf("corrupted lane %0d link_up", i), 16'd0, 16'(link_up[i]));
            end
            else
                check_lane_up(i, "negotiated");
        end

        // One disparity error hits the first byte of err_lane and plain idles follow
        for (int s = 0; s < POST_SLOTS; s++)
            for (int b = 0; b < SLOT_BYTES; b++)
                for (int lane = 0; lane < NUM_LANES; lane++)
                    drive_byte(line_code(lane, idle_code(b)),
                        (s == 0) && (b == 0) && (lane == err_lane));
        @(negedge tbi_rx_clk);
        for (int i = 0; i < NUM_LANES; i++)
        begin
            if ((i == err_lane) || (i == bad_lane))
            begin
                check_value($sformatf("dropped lane %0d an_done", i), 16'd0, 16'(an_done[i]));
                check_value($sformatf("dropped lane %0d link_up", i), 16'd0, 16'(link_up[i]));
                check_value($sformatf("dropped lane %0d full_duplex", i), 16'd0,
                    16'(full_duplex[i]));
            end
            else
                check_lane_up(i, "after error");
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log for the pass line

cd "$(dirname "$0")" || exit 1

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module tb_qsgmii_rx -f verilog.f -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^Finished with no errors$" "$LOG"; then
    exit 0
fi
exit 1

// ==== src/qsgmii_lane_demux.sv ====
/*
 * Splits the interleaved QSGMII byte stream into per-lane strobes.
 * The stream must carry one byte every clock. Bytes leave two clocks after they
 * arrive, and no lane_valid is issued before the first K28.1 after reset.
 */
`timescale 1ns/10ps

module qsgmii_lane_demux
    import tbi_pkg::*;
#(
    parameter int NUM_LANES = 4
)
(
    input  logic                 tbi_rx_clk,
    input  logic                 rst,
    input  tbi_byte_t            rx_byte,
    input  logic                 rx_is_k,
    input  logic                 rx_disp_err,
    output tbi_byte_t            lane_byte,
    output logic                 lane_is_k,
    output logic                 lane_disp_err,
    output logic [NUM_LANES-1:0] lane_valid,
    output logic                 lane_aligned
);

    localparam int LANE_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

    tbi_byte_t in_byte;
    logic in_is_k;
    logic in_disp_err;
    logic lane0_comma;
    logic [LANE_W-1:0] lane_cnt;
    logic [LANE_W-1:0] lane_cur;
    logic [NUM_LANES-1:0] lane_onehot;

    always_ff @(posedge tbi_rx_clk or posedge rst)
    begin
        if (rst)
        begin
            in_is_k <= 1'b0;
            in_disp_err <= 1'b0;
        end
        else
        begin
            in_is_k <= rx_is_k;
            in_disp_err <= rx_disp_err;
        end
    end

    always_ff @(posedge tbi_rx_clk)
    begin
        in_byte <= rx_byte;
        lane_byte <= lane0_comma ? K28_5 : in_byte;
    end

    // K28.1 only ever appears in lane 0 and pins the lane counter
    assign lane0_comma = in_is_k && (in_byte == K28_1);
    assign lane_cur = lane0_comma ? '0 : lane_cnt;

    always_comb
    begin
        lane_onehot = '0;
        lane_onehot[lane_cur] = 1'b1;
    end

    always_ff @(posedge tbi_rx_clk or posedge rst)
    begin
        if (rst)
        begin
            lane_cnt <= '0;
            lane_is_k <= 1'b0;
            lane_disp_err <= 1'b0;
            lane_valid <= '0;
            lane_aligned <= 1'b0;
        end
        else
        begin
            lane_cnt <= (lane_cur == LANE_W'(NUM_LANES - 1)) ? '0 : lane_cur + 1'b1;
            lane_is_k <= in_is_k;
            lane_disp_err <= in_disp_err;
            lane_aligned <= lane_aligned || lane0_comma;
            lane_valid <= (lane_aligned || lane0_comma) ? lane_onehot : '0;
        end
    end

    a_valid_onehot: assert property (@(posedge tbi_rx_clk) disable iff (rst)
        $onehot0(lane_valid) && (lane_aligned || (lane_valid == '0)));

endmodule

// ==== src/qsgmii_rx_top.sv ====
/*
 * QSGMII receive side: lane alignment, per-lane auto-negotiation and link status.
 * Expects 8b/10b decoded bytes at one per clock with no back-pressure.
 */
`timescale 1ns/10ps

module qsgmii_rx_top
    import tbi_pkg::*, sgmii_pkg::*;
#(
    parameter int NUM_LANES = 4,
    parameter int CFG_COUNT = 1000
)
(
    input  logic                        tbi_rx_clk,
    input  logic                        rst,
    input  tbi_byte_t                   rx_byte,
    input  logic                        rx_is_k,
    input  logic                        rx_disp_err,
    output logic                        lane_aligned,
    output logic        [NUM_LANES-1:0] an_start,
    output logic        [NUM_LANES-1:0] an_ack,
    output logic        [NUM_LANES-1:0] an_idle,
    output logic        [NUM_LANES-1:0] an_done,
    output logic        [NUM_LANES-1:0] link_up,
    output logic        [NUM_LANES-1:0] full_duplex,
    output link_speed_t [NUM_LANES-1:0] link_speed
);

    tbi_byte_t lane_byte;
    logic lane_is_k;
    logic lane_disp_err;
    logic [NUM_LANES-1:0] lane_valid;
    sgmii_cfg_t [NUM_LANES-1:0] lane_config;

    qsgmii_lane_demux #(.NUM_LANES(NUM_LANES)) u_demux (
        .tbi_rx_clk    (tbi_rx_clk),
        .rst           (rst),
        .rx_byte       (rx_byte),
        .rx_is_k       (rx_is_k),
        .rx_disp_err   (rx_disp_err),
        .lane_byte     (lane_byte),
        .lane_is_k     (lane_is_k),
        .lane_disp_err (lane_disp_err),
        .lane_valid    (lane_valid),
        .lane_aligned  (lane_aligned)
    );

    // Every receiver sees the shared byte but only acts on its own strobe
    for (genvar i = 0; i < NUM_LANES; i++)
    begin : g_lane
        sgmii_autoneg #(.CFG_COUNT(CFG_COUNT)) u_autoneg (
            .tbi_rx_clk          (tbi_rx_clk),
            .rst                 (rst),
            .rx_valid            (lane_valid[i]),
            .rx_byte             (lane_byte),
            .rx_is_k             (lane_is_k),
            .rx_disp_err         (lane_disp_err),
            .sgmii_autoneg_start (an_start[i]),
            .sgmii_autoneg_ack   (an_ack[i]),
            .sgmii_autoneg_idle  (an_idle[i]),
            .sgmii_autoneg_done  (an_done[i]),
            .sgmii_config        (lane_config[i])
        );
    end

    sgmii_link_status #(.NUM_LANES(NUM_LANES)) u_status (
        .tbi_rx_clk  (tbi_rx_clk),
        .rst         (rst),
        .an_done     (an_done),
        .lane_config (lane_config),
        .link_up     (link_up),
        .full_duplex (full_duplex),
        .link_speed  (link_speed)
    );

endmodule

// ==== src/sgmii_autoneg.sv ====
/*
 * SGMII auto-negotiation receiver for one lane, advanced by the rx_valid strobe.
 * Needs CFG_COUNT /C/ pairs after the first, then a valid ability word, its ack
 * and three more identical pairs, then two idle pairs. Any error restarts it.
 */
`timescale 1ns/10ps

module sgmii_autoneg
    import tbi_pkg::*, sgmii_pkg::*;
#(
    parameter int CFG_COUNT = 1000
)
(
    input  logic       tbi_rx_clk,
    input  logic       rst,
    input  logic       rx_valid,
    input  tbi_byte_t  rx_byte,
    input  logic       rx_is_k,
    input  logic       rx_disp_err,
    output logic       sgmii_autoneg_start,
    output logic       sgmii_autoneg_ack,
    output logic       sgmii_autoneg_idle,
    output logic       sgmii_autoneg_done,
    output sgmii_cfg_t sgmii_config
);

    localparam int CNT_W = $clog2(CFG_COUNT + 4);

    an_phase_t phase;
    an_phase_t pair_next;
    logic [2:0] pos;
    logic [CNT_W-1:0] cfg_cnt;
    sgmii_cfg_t cfg1;
    tbi_byte_t cfg2_lo;
    sgmii_cfg_t cfg2_full;
    logic is_comma;
    logic cfg_marker;
    logic cfg_byte_ok;
    logic idle_byte_ok;
    logic pair_mismatch;
    logic rx_error;

    assign is_comma = rx_is_k && (rx_byte == K28_5);
    assign cfg_marker = !rx_is_k && ((rx_byte == D21_5) || (rx_byte == D2_2));
    assign rx_error = rx_disp_err || (rx_is_k && (rx_byte == K_ZERO));

    // At the last position of a pair the current byte completes cfg2
    assign cfg2_full = {rx_byte, cfg2_lo};
    assign pair_mismatch = (cfg1 != cfg2_full);

    // A config pair is K28.5 D21.5 cfg1 cfg1 K28.5 D2.2 cfg2 cfg2
    always_comb
    begin
        case (pos)
        3'd0, 3'd4: cfg_byte_ok = is_comma;
        3'd1: cfg_byte_ok = !rx_is_k && (rx_byte == D21_5);
        3'd5: cfg_byte_ok = !rx_is_k && (rx_byte == D2_2);
        default: cfg_byte_ok = !rx_is_k;
        endcase
    end

    // Two idle pairs are /I1/ /I2/ /I1/ /I2/
    always_comb
    begin
        case (pos)
        3'd1, 3'd5: idle_byte_ok = !rx_is_k && (rx_byte == D5_6);
        3'd3, 3'd7: idle_byte_ok = !rx_is_k && (rx_byte == D16_2);
        default: idle_byte_ok = is_comma;
        endcase
    end

    always_comb
    begin
        pair_next = phase;
        case (phase)
        SEARCH: pair_next = COUNT;
        COUNT:
            if (cfg_cnt == CNT_W'(CFG_COUNT))
                pair_next = WAIT_ABILITY;
        WAIT_ABILITY:
            if (pair_mismatch)
                pair_next = RESTART;
            else if (cfg1[CFG_VALID_BIT])
                pair_next = WAIT_ACK;
        WAIT_ACK:
            if (pair_mismatch || !cfg1[CFG_VALID_BIT])
                pair_next = RESTART;
            else if (cfg2_full[CFG_ACK_BIT])
                pair_next = CONFIRM;
        CONFIRM:
            if (pair_mismatch || (cfg1 != sgmii_config))
                pair_next = RESTART;
            else if (cfg_cnt == CNT_W'(CFG_COUNT + 3))
                pair_next = WAIT_IDLE;
        default: pair_next = phase;
        endcase
    end

    always_ff @(posedge tbi_rx_clk)
    begin
        if (rx_valid)
        begin
            case (pos)
            3'd2: cfg1[7:0] <= rx_byte;
            3'd3: cfg1[15:8] <= rx_byte;
            3'd6: cfg2_lo <= rx_byte;
            default: ;
            endcase
        end
    end

    always_ff @(posedge tbi_rx_clk or posedge rst)
    begin
        if (rst)
        begin
            phase <= RESTART;
            pos <= 3'd0;
            cfg_cnt <= '0;
            sgmii_autoneg_start <= 1'b0;
            sgmii_autoneg_ack <= 1'b0;
            sgmii_autoneg_idle <= 1'b0;
            sgmii_autoneg_done <= 1'b0;
            sgmii_config <= '0;
        end
        else if (rx_valid)
        begin
            pos <= pos + 3'd1;
            case (phase)
            RESTART:
            begin
                phase <= SEARCH;
                pos <= 3'd0;
                cfg_cnt <= '0;
                sgmii_autoneg_start <= 1'b0;
                sgmii_autoneg_ack <= 1'b0;
                sgmii_autoneg_idle <= 1'b0;
                sgmii_autoneg_done <= 1'b0;
                sgmii_config <= '0;
            end
            SEARCH:
            begin
                // A bad comma or D21.5 only resyncs the search
                if (!cfg_byte_ok)
                begin
                    phase <= (pos < 3'd2) ? SEARCH : RESTART;
                    pos <= 3'd0;
                end
                else if (pos == 3'd7)
                    phase <= pair_next;
            end
            COUNT, WAIT_ABILITY, WAIT_ACK, CONFIRM:
            begin
                if (!cfg_byte_ok)
                    phase <= RESTART;
                else if (pos == 3'd2)
                begin
                    if ((phase == COUNT) || (phase == CONFIRM))
                        cfg_cnt <= cfg_cnt + 1'b1;
                    if (phase == COUNT)
                        sgmii_autoneg_start <= 1'b1;
                    if (phase == WAIT_ACK)
                        sgmii_autoneg_ack <= 1'b1;
                end
                else if (pos == 3'd7)
                begin
                    phase <= pair_next;
                    if ((phase == WAIT_ABILITY) || (phase == WAIT_ACK))
                        sgmii_config <= cfg1;
                end
            end
            WAIT_IDLE:
            begin
                sgmii_autoneg_idle <= 1'b1;
                if (!idle_byte_ok)
                    pos <= 3'd0;
                else if (pos == 3'd7)
                begin
                    phase <= DONE;
                    sgmii_autoneg_done <= 1'b1;
                end
            end
            DONE:
            begin
                // A new /C/ set means the link partner restarted negotiation
                if (rx_error || ((pos == 3'd1) && cfg_marker))
                begin
                    phase <= RESTART;
                    sgmii_autoneg_done <= 1'b0;
                end
                else
                    pos <= ((pos == 3'd0) && is_comma) ? 3'd1 : 3'd0;
            end
            endcase
        end
    end

    // Done can only be reached through every earlier step of the sequence
    a_done_in_done: assert property (@(posedge tbi_rx_clk) disable iff (rst)
        sgmii_autoneg_done |-> (phase == DONE) && sgmii_autoneg_start
            && sgmii_autoneg_ack && sgmii_autoneg_idle);

endmodule

// ==== src/sgmii_link_status.sv ====
/*
 * Per-lane link status taken from the config word when negotiation completes.
 * Status holds while an_done stays high and clears when it falls.
 */
`timescale 1ns/10ps

module sgmii_link_status
    import sgmii_pkg::*;
#(
    parameter int NUM_LANES = 4
)
(
    input  logic                              tbi_rx_clk,
    input  logic                              rst,
    input  logic        [NUM_LANES-1:0]       an_done,
    input  sgmii_cfg_t  [NUM_LANES-1:0]       lane_config,
    output logic        [NUM_LANES-1:0]       link_up,
    output logic        [NUM_LANES-1:0]       full_duplex,
    output link_speed_t [NUM_LANES-1:0]       link_speed
);

    logic [NUM_LANES-1:0] done_q;

    function automatic link_speed_t decode_speed(input logic [1:0] field);
        link_speed_t speed;
        case (field)
        2'b00: speed = SPEED_10;
        2'b01: speed = SPEED_100;
        2'b10: speed = SPEED_1000;
        default: speed = SPEED_RSVD;
        endcase
        return speed;
    endfunction

    always_ff @(posedge tbi_rx_clk or posedge rst)
    begin
        if (rst)
        begin
            done_q <= '0;
            link_up <= '0;
            full_duplex <= '0;
            for (int i = 0; i < NUM_LANES; i++)
                link_speed[i] <= SPEED_10;
        end
        else
        begin
            done_q <= an_done;
            for (int i = 0; i < NUM_LANES; i++)
            begin
                if (an_done[i] && !done_q[i])
                begin
                    link_up[i] <= lane_config[i][CFG_LINK_BIT];
                    full_duplex[i] <= lane_config[i][CFG_DUPLEX_BIT];
                    link_speed[i] <= decode_speed(lane_config[i][CFG_SPEED_MSB:CFG_SPEED_LSB]);
                end
                else if (!an_done[i] && done_q[i])
                begin
                    link_up[i] <= 1'b0;
                    full_duplex[i] <= 1'b0;
                    link_speed[i] <= SPEED_10;
                end
            end
        end
    end

    for (genvar i = 0; i < NUM_LANES; i++)
    begin : g_chk
        a_link_needs_done: assert property (@(posedge tbi_rx_clk) disable iff (rst)
            $rose(link_up[i]) |-> an_done[i]);
    end

endmodule

// ==== src/sgmii_pkg.sv ====
/*
 * SGMII auto-negotiation types and config word layout (PHY to MAC direction).
 * Only the link, duplex, ack, speed and valid fields are interpreted.
 */
package sgmii_pkg;

    typedef logic [15:0] sgmii_cfg_t;

    typedef enum logic [2:0] {
        RESTART,
        SEARCH,
        COUNT,
        WAIT_ABILITY,
        WAIT_ACK,
        CONFIRM,
        WAIT_IDLE,
        DONE
    } an_phase_t;

    typedef enum logic [1:0] {
        SPEED_10 = 2'b00,
        SPEED_100 = 2'b01,
        SPEED_1000 = 2'b10,
        SPEED_RSVD = 2'b11
    } link_speed_t;

    localparam int CFG_VALID_BIT = 0;
    localparam int CFG_SPEED_LSB = 10;
    localparam int CFG_SPEED_MSB = 11;
    localparam int CFG_DUPLEX_BIT = 12;
    localparam int CFG_ACK_BIT = 14;
    localparam int CFG_LINK_BIT = 15;

endpackage

// ==== src/tbi_pkg.sv ====
/*
 * Decoded ten-bit interface code-groups, as delivered by an upstream 8b/10b decoder.
 * The K flag and the disparity error travel beside the byte and are not part of it.
 */
package tbi_pkg;

    typedef logic [7:0] tbi_byte_t;

    // Control code-groups, only meaningful with the K flag set
    localparam tbi_byte_t K28_5 = 8'hBC;
    localparam tbi_byte_t K28_1 = 8'h3C;
    localparam tbi_byte_t K_ZERO = 8'h00;

    // Data code-groups that follow the comma in the /C/ and /I/ ordered sets
    localparam tbi_byte_t D21_5 = 8'hB5;
    localparam tbi_byte_t D2_2 = 8'h42;
    localparam tbi_byte_t D5_6 = 8'hC5;
    localparam tbi_byte_t D16_2 = 8'h50;

endpackage

// ==== verilog.f ====
src/tbi_pkg.sv
src/sgmii_pkg.sv
src/qsgmii_lane_demux.sv
src/sgmii_autoneg.sv
src/sgmii_link_status.sv
src/qsgmii_rx_top.sv
dv/tb_qsgmii_rx.sv
